// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  addr_t;
    typedef logic [2:0]  reg_idx_t;

    localparam int NUM_REGS = 8;

    // Instruction fields
    localparam int OP_MSB   = 15;
    localparam int OP_LSB   = 11;
    localparam int R1_MSB   = 10;
    localparam int R1_LSB   = 8;
    localparam int R2_MSB   = 6;
    localparam int R2_LSB   = 4;
    localparam int R3_MSB   = 2;
    localparam int R3_LSB   = 0;
    localparam int IMM8_MSB = 7;
    localparam int IMM4_MSB = 3;

    typedef enum logic [4:0] {
        OP_NOP  = 5'b00000, OP_HALT = 5'b00001, OP_LOAD = 5'b00010, OP_STORE = 5'b00011,
        OP_SLL  = 5'b00100, OP_SLA  = 5'b00101, OP_SRL  = 5'b00110, OP_SRA   = 5'b00111,
        OP_ADD  = 5'b01000, OP_ADDI = 5'b01001, OP_SUB  = 5'b01010, OP_SUBI  = 5'b01011,
        OP_CMP  = 5'b01100, OP_AND  = 5'b01101, OP_OR   = 5'b01110, OP_XOR   = 5'b01111,
        OP_LDIH = 5'b10000, OP_ADDC = 5'b10001, OP_SUBC = 5'b10010,
        OP_JUMP = 5'b11000, OP_JMPR = 5'b11001, OP_BZ   = 5'b11010, OP_BNZ   = 5'b11011,
        OP_BN   = 5'b11100, OP_BNN  = 5'b11101, OP_BC   = 5'b11110, OP_BNC   = 5'b11111
    } opcode_t;

    //////////////////////////////////////////////////////////////////////
    // Field extraction

    function automatic opcode_t get_op(input word_t ir);
        return opcode_t'(ir[OP_MSB:OP_LSB]);
    endfunction

    function automatic reg_idx_t get_r1(input word_t ir);
        return ir[R1_MSB:R1_LSB];
    endfunction

    function automatic reg_idx_t get_r2(input word_t ir);
        return ir[R2_MSB:R2_LSB];
    endfunction

    function automatic reg_idx_t get_r3(input word_t ir);
        return ir[R3_MSB:R3_LSB];
    endfunction

    function automatic word_t get_imm8(input word_t ir);
        return {8'h00, ir[IMM8_MSB:0]};
    endfunction

    function automatic word_t get_imm4(input word_t ir);
        return {12'h000, ir[IMM4_MSB:0]};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Instruction classes

    function automatic logic is_cond_branch(input word_t ir);
        return get_op(ir) inside {OP_BZ, OP_BNZ, OP_BN, OP_BNN, OP_BC, OP_BNC};
    endfunction

    function automatic logic writes_reg(input word_t ir);
        return get_op(ir) inside {OP_LOAD, OP_LDIH, OP_ADD, OP_ADDI, OP_ADDC, OP_SUB,
                                  OP_SUBI, OP_SUBC, OP_AND, OP_OR, OP_XOR,
                                  OP_SLL, OP_SRL, OP_SLA, OP_SRA};
    endfunction

    function automatic logic is_forward_source(input word_t ir);
        return !(is_cond_branch(ir) || get_op(ir) inside {OP_JMPR, OP_NOP, OP_CMP});
    endfunction

    // Store data is also R1
    function automatic logic uses_r1_source(input word_t ir);
        return is_cond_branch(ir) ||
               get_op(ir) inside {OP_STORE, OP_ADDI, OP_SUBI, OP_LDIH, OP_JMPR};
    endfunction

    function automatic logic uses_r3_source(input word_t ir);
        return get_op(ir) inside {OP_ADD, OP_ADDC, OP_SUB, OP_SUBC, OP_CMP,
                                  OP_AND, OP_OR, OP_XOR};
    endfunction

    function automatic logic sets_zn(input word_t ir);
        return get_op(ir) inside {OP_LDIH, OP_ADD, OP_ADDI, OP_ADDC, OP_SUB,
                                  OP_SUBI, OP_SUBC, OP_CMP};
    endfunction

    function automatic logic sets_carry(input word_t ir);
        return get_op(ir) inside {OP_ADD, OP_ADDI, OP_ADDC, OP_SUB, OP_SUBI,
                                  OP_SUBC, OP_CMP};
    endfunction

endpackage

// ==== hw/pipe_if.sv ====
interface pipe_if;
    import cpu_pkg::*;

    logic  run;
    logic  flush;
    word_t ex_ir;
    word_t alu_result;
    word_t mem_ir;
    word_t mem_result;
    word_t load_data;
    word_t wb_ir;
    word_t wb_result;

    modport control (output run, input wb_ir);

    modport fetch (input run, flush, mem_result);

    modport decode (
        input  run, flush, alu_result, mem_ir, mem_result, load_data, wb_ir, wb_result,
        output ex_ir
    );

    modport execute (input run, flush, output alu_result, mem_ir, mem_result);

    modport memory (input run, mem_ir, mem_result, output flush, load_data, wb_ir, wb_result);

    modport regfile (input run, wb_ir, wb_result);

endinterface

// ==== hw/cpu_control.sv ====
module cpu_control (
    input  logic     i_clock,
    input  logic     i_reset,
    input  logic     i_enable,
    input  logic     i_start,
    pipe_if.control  ctl
);
    import cpu_pkg::*;

    typedef enum logic {ST_IDLE, ST_RUN} state_t;

    state_t state;
    state_t state_next;

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:
                if (i_enable && i_start)
                    state_next = ST_RUN;
            ST_RUN:
                // HALT has left every younger stage behind it
                if (!i_enable || get_op(ctl.wb_ir) == OP_HALT)
                    state_next = ST_IDLE;
            default:
                state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clock or negedge i_reset)
    begin
        if (!i_reset)
            state <= ST_IDLE;
        else
            state <= state_next;
    end

    assign ctl.run = (state == ST_RUN);

endmodule

// ==== hw/fetch_stage.sv ====
module fetch_stage (
    input  logic            i_clock,
    input  logic            i_reset,
    input  cpu_pkg::word_t  i_instr,
    output cpu_pkg::addr_t  o_pc,
    output cpu_pkg::word_t  o_id_ir,
    pipe_if.fetch           ctl
);
    import cpu_pkg::*;

    reg_idx_t load_dst;
    logic     reads_r2;
    logic     load_use;

    // R2 is the base, shift source or first ALU operand
    assign reads_r2 = uses_r3_source(i_instr) ||
                      get_op(i_instr) inside {OP_LOAD, OP_STORE, OP_SLL, OP_SRL,
                                              OP_SLA, OP_SRA};

    // Load in decode feeding the instruction now being fetched
    assign load_dst = get_r1(o_id_ir);
    assign load_use = (get_op(o_id_ir) == OP_LOAD) &&
                      ((uses_r1_source(i_instr) && get_r1(i_instr) == load_dst) ||
                       (uses_r3_source(i_instr) && get_r3(i_instr) == load_dst) ||
                       (reads_r2 && get_r2(i_instr) == load_dst));

    always_ff @(posedge i_clock or negedge i_reset)
    begin
        if (!i_reset)
        begin
            o_pc    <= '0;
            o_id_ir <= '0;
        end
        else if (ctl.run)
        begin
            if (ctl.flush)
            begin
                o_pc    <= ctl.mem_result[7:0];
                o_id_ir <= '0;
            end
            else if (load_use)
            begin
                // Bubble while the same word is fetched again
                o_id_ir <= '0;
            end
            else
            begin
                o_pc    <= o_pc + 8'd1;
                o_id_ir <= i_instr;
            end
        end
    end

endmodule

// ==== hw/decode_stage.sv ====
module decode_stage (
    input  logic               i_clock,
    input  logic               i_reset,
    input  cpu_pkg::word_t     i_id_ir,
    input  cpu_pkg::word_t     i_rd_a,
    input  cpu_pkg::word_t     i_rd_b,
    input  cpu_pkg::word_t     i_rd_s,
    output cpu_pkg::reg_idx_t  o_ra_idx,
    output cpu_pkg::reg_idx_t  o_rb_idx,
    output cpu_pkg::reg_idx_t  o_rs_idx,
    output cpu_pkg::word_t     o_op_a,
    output cpu_pkg::word_t     o_op_b,
    output cpu_pkg::word_t     o_store_data,
    pipe_if.decode             pipe
);
    import cpu_pkg::*;

    opcode_t op;
    logic    a_from_r1;
    logic    b_is_imm4;
    logic    b_is_imm8;
    word_t   fwd_a;
    word_t   fwd_b;
    word_t   fwd_s;
    word_t   next_b;

    function automatic logic hits(input word_t ir, input reg_idx_t idx);
        return is_forward_source(ir) && writes_reg(ir) && get_r1(ir) == idx;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Operand bypass, youngest producer first

    function automatic word_t forward(input reg_idx_t idx, input word_t rf_value);
        if (hits(pipe.ex_ir, idx))
            return pipe.alu_result;
        else if (hits(pipe.mem_ir, idx) && get_op(pipe.mem_ir) == OP_LOAD)
            return pipe.load_data;
        else if (hits(pipe.mem_ir, idx))
            return pipe.mem_result;
        else if (hits(pipe.wb_ir, idx))
            return pipe.wb_result;
        else
            return rf_value;
    endfunction

    assign op        = get_op(i_id_ir);
    // STORE takes its address base from R2
    assign a_from_r1 = uses_r1_source(i_id_ir) && op != OP_STORE;
    assign b_is_imm4 = op inside {OP_LOAD, OP_STORE, OP_SLL, OP_SRL, OP_SLA, OP_SRA};
    assign b_is_imm8 = is_cond_branch(i_id_ir) ||
                       op inside {OP_LDIH, OP_ADDI, OP_SUBI, OP_JUMP, OP_JMPR};

    assign o_ra_idx = a_from_r1 ? get_r1(i_id_ir) : get_r2(i_id_ir);
    assign o_rb_idx = get_r3(i_id_ir);
    assign o_rs_idx = get_r1(i_id_ir);

    always_comb
    begin
        fwd_a = forward(o_ra_idx, i_rd_a);
        fwd_b = forward(o_rb_idx, i_rd_b);
        fwd_s = forward(o_rs_idx, i_rd_s);
        if (b_is_imm4)
            next_b = get_imm4(i_id_ir);
        else if (b_is_imm8)
            next_b = get_imm8(i_id_ir);
        else
            next_b = fwd_b;
    end

    always_ff @(posedge i_clock or negedge i_reset)
    begin
        if (!i_reset)
            pipe.ex_ir <= '0;
        else if (pipe.run)
            pipe.ex_ir <= pipe.flush ? '0 : i_id_ir;
    end

    always_ff @(posedge i_clock)
    begin
        if (pipe.run)
        begin
            o_op_a       <= fwd_a;
            o_op_b       <= next_b;
            o_store_data <= fwd_s;
        end
    end

endmodule

// ==== hw/register_file.sv ====
module register_file (
    input  logic               i_clock,
    input  logic               i_reset,
    input  cpu_pkg::reg_idx_t  i_ra_idx,
    input  cpu_pkg::reg_idx_t  i_rb_idx,
    input  cpu_pkg::reg_idx_t  i_rs_idx,
    output cpu_pkg::word_t     o_rd_a,
    output cpu_pkg::word_t     o_rd_b,
    output cpu_pkg::word_t     o_rd_s,
    pipe_if.regfile            pipe
);
    import cpu_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge i_clock or negedge i_reset)
    begin
        if (!i_reset)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (pipe.run && writes_reg(pipe.wb_ir))
            regs[get_r1(pipe.wb_ir)] <= pipe.wb_result;
    end

    assign o_rd_a = regs[i_ra_idx];
    assign o_rd_b = regs[i_rb_idx];
    assign o_rd_s = regs[i_rs_idx];

endmodule

// ==== hw/execute_stage.sv ====
module execute_stage (
    input  logic            i_clock,
    input  logic            i_reset,
    input  cpu_pkg::word_t  i_ex_ir,
    input  cpu_pkg::word_t  i_store_data,
    input  cpu_pkg::word_t  i_alu_result,
    input  logic            i_alu_carry,
    output logic            o_carry,
    output logic            o_zero,
    output logic            o_neg,
    output logic            o_d_we,
    output cpu_pkg::word_t  o_d_dataout,
    pipe_if.execute         pipe
);
    import cpu_pkg::*;

    logic store_q;
    logic keep;

    assign pipe.alu_result = i_alu_result;
    assign keep            = !pipe.flush;

    // A held store writes once, on the first running edge
    assign o_d_we = store_q && pipe.run;

    always_ff @(posedge i_clock or negedge i_reset)
    begin
        if (!i_reset)
        begin
            pipe.mem_ir <= '0;
            store_q     <= 1'b0;
            o_carry     <= 1'b0;
            o_zero      <= 1'b0;
            o_neg       <= 1'b0;
        end
        else if (pipe.run)
        begin
            pipe.mem_ir <= keep ? i_ex_ir : '0;
            store_q     <= keep && get_op(i_ex_ir) == OP_STORE;
            if (keep && sets_zn(i_ex_ir))
            begin
                o_zero <= (i_alu_result == '0);
                o_neg  <= i_alu_result[15];
            end
            if (keep && sets_carry(i_ex_ir))
                o_carry <= i_alu_carry;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (pipe.run)
        begin
            pipe.mem_result <= i_alu_result;
            o_d_dataout     <= i_store_data;
        end
    end

endmodule

// ==== hw/alu.sv ====
module alu (
    input  cpu_pkg::word_t  i_ir,
    input  cpu_pkg::word_t  i_op_a,
    input  cpu_pkg::word_t  i_op_b,
    input  logic            i_carry,
    output cpu_pkg::word_t  o_result,
    output logic            o_carry
);
    import cpu_pkg::*;

    logic [3:0] shamt;

    assign shamt = i_op_b[3:0];

    always_comb
    begin
        o_result = '0;
        o_carry  = 1'b0;
        case (get_op(i_ir))
            // Address and branch target
            OP_LOAD, OP_STORE, OP_JMPR, OP_BZ, OP_BNZ, OP_BN, OP_BNN, OP_BC, OP_BNC:
                o_result = i_op_a + i_op_b;
            OP_LDIH:
                o_result = i_op_a + {i_op_b[7:0], 8'h00};
            OP_ADD, OP_ADDI:
                {o_carry, o_result} = {1'b0, i_op_a} + {1'b0, i_op_b};
            OP_ADDC:
                {o_carry, o_result} = {1'b0, i_op_a} + {1'b0, i_op_b} + {16'h0000, i_carry};
            // Carry out is the borrow
            OP_SUB, OP_SUBI, OP_CMP:
                {o_carry, o_result} = {1'b0, i_op_a} - {1'b0, i_op_b};
            OP_SUBC:
                {o_carry, o_result} = {1'b0, i_op_a} - {1'b0, i_op_b} - {16'h0000, i_carry};
            OP_AND:  o_result = i_op_a & i_op_b;
            OP_OR:   o_result = i_op_a | i_op_b;
            OP_XOR:  o_result = i_op_a ^ i_op_b;
            OP_SLL:  o_result = i_op_a << shamt;
            OP_SRL:  o_result = i_op_a >> shamt;
            OP_SLA:  o_result = word_t'($signed(i_op_a) <<< shamt);
            OP_SRA:  o_result = word_t'($signed(i_op_a) >>> shamt);
            OP_JUMP: o_result = i_op_b;
            default: o_result = '0;
        endcase
    end

endmodule

// ==== hw/memory_stage.sv ====
module memory_stage (
    input  logic            i_clock,
    input  logic            i_reset,
    input  logic            i_zero,
    input  logic            i_neg,
    input  logic            i_carry,
    input  cpu_pkg::word_t  i_d_data,
    output cpu_pkg::addr_t  o_d_addr,
    pipe_if.memory          pipe
);
    import cpu_pkg::*;

    opcode_t op;
    logic    taken;

    assign op = get_op(pipe.mem_ir);

    always_comb
    begin
        case (op)
            OP_JUMP, OP_JMPR: taken = 1'b1;
            OP_BZ:   taken = i_zero;
            OP_BNZ:  taken = !i_zero;
            OP_BN:   taken = i_neg;
            OP_BNN:  taken = !i_neg;
            OP_BC:   taken = i_carry;
            OP_BNC:  taken = !i_carry;
            default: taken = 1'b0;
        endcase
    end

    assign pipe.flush     = taken;
    assign pipe.load_data = i_d_data;
    assign o_d_addr       = pipe.mem_result[7:0];

    always_ff @(posedge i_clock or negedge i_reset)
    begin
        if (!i_reset)
            pipe.wb_ir <= '0;
        else if (pipe.run)
            pipe.wb_ir <= taken ? '0 : pipe.mem_ir;
    end

    always_ff @(posedge i_clock)
    begin
        if (pipe.run)
            pipe.wb_result <= (op == OP_LOAD) ? i_d_data : pipe.mem_result;
    end

endmodule

// ==== hw/cpu_top.sv ====
module cpu_top (
    input  logic            i_clock,
    input  logic            i_reset,
    input  logic            i_enable,
    input  logic            i_start,
    input  cpu_pkg::word_t  i_i_data,
    input  cpu_pkg::word_t  i_d_data,
    output cpu_pkg::addr_t  o_i_addr,
    output cpu_pkg::addr_t  o_d_addr,
    output cpu_pkg::word_t  o_d_dataout,
    output logic            o_d_we,
    output logic            o_running
);
    import cpu_pkg::*;

    word_t    id_ir;
    reg_idx_t ra_idx;
    reg_idx_t rb_idx;
    reg_idx_t rs_idx;
    word_t    rd_a;
    word_t    rd_b;
    word_t    rd_s;
    word_t    op_a;
    word_t    op_b;
    word_t    store_data;
    word_t    alu_result;
    logic     alu_carry;
    logic     carry;
    logic     zero;
    logic     neg;

    pipe_if pipe ();

    assign o_running = pipe.run;

    cpu_control u_control (.i_clock, .i_reset, .i_enable, .i_start, .ctl(pipe));

    fetch_stage u_fetch (
        .i_clock, .i_reset, .i_instr(i_i_data), .o_pc(o_i_addr), .o_id_ir(id_ir), .ctl(pipe)
    );

    decode_stage u_decode (
        .i_clock, .i_reset, .i_id_ir(id_ir),
        .i_rd_a(rd_a), .i_rd_b(rd_b), .i_rd_s(rd_s),
        .o_ra_idx(ra_idx), .o_rb_idx(rb_idx), .o_rs_idx(rs_idx),
        .o_op_a(op_a), .o_op_b(op_b), .o_store_data(store_data), .pipe(pipe)
    );

    register_file u_regs (
        .i_clock, .i_reset, .i_ra_idx(ra_idx), .i_rb_idx(rb_idx), .i_rs_idx(rs_idx),
        .o_rd_a(rd_a), .o_rd_b(rd_b), .o_rd_s(rd_s), .pipe(pipe)
    );

    alu u_alu (
        .i_ir(pipe.ex_ir), .i_op_a(op_a), .i_op_b(op_b), .i_carry(carry),
        .o_result(alu_result), .o_carry(alu_carry)
    );

    execute_stage u_execute (
        .i_clock, .i_reset, .i_ex_ir(pipe.ex_ir), .i_store_data(store_data),
        .i_alu_result(alu_result), .i_alu_carry(alu_carry),
        .o_carry(carry), .o_zero(zero), .o_neg(neg),
        .o_d_we, .o_d_dataout, .pipe(pipe)
    );

    memory_stage u_memory (
        .i_clock, .i_reset, .i_zero(zero), .i_neg(neg), .i_carry(carry),
        .i_d_data, .o_d_addr, .pipe(pipe)
    );

endmodule

// ==== tb/tb_programs.svh ====
// Instruction encoders for the program table

function automatic word_t rrr_word(opcode_t op, int r1, int r2, int r3);
    return {op, r1[2:0], 1'b0, r2[2:0], 1'b0, r3[2:0]};
endfunction

function automatic word_t ri8_word(opcode_t op, int r1, int imm8);
    return {op, r1[2:0], imm8[7:0]};
endfunction

function automatic word_t rri4_word(opcode_t op, int r1, int r2, int imm4);
    return {op, r1[2:0], 1'b0, r2[2:0], imm4[3:0]};
endfunction

//////////////////////////////////////////////////////////////////////
// Test table, one row per run

localparam int NUM_ROWS  = 6;
localparam int NUM_WORDS = 93;

localparam int PROG_START  [NUM_ROWS] = '{0, 20, 33, 57, 81, 81};
localparam int PROG_LEN    [NUM_ROWS] = '{20, 13, 24, 24, 12, 12};
// Cycles after start before enable drops, -1 for none
localparam int DROP_CYCLE  [NUM_ROWS] = '{-1, -1, -1, -1, -1, 6};
localparam int STORE_COUNT [NUM_ROWS] = '{7, 4, 4, 5, 3, 3};

localparam word_t PROGRAM_WORDS [NUM_WORDS] = '{
    // Dependent ALU chain
    ri8_word(OP_LDIH, 1, 8'h12), ri8_word(OP_ADDI, 1, 8'h34), rrr_word(OP_ADD, 2, 1, 1),
    rrr_word(OP_SUB, 3, 2, 1), rrr_word(OP_XOR, 4, 3, 2), rri4_word(OP_SLL, 5, 4, 3),
    rri4_word(OP_SRA, 6, 5, 2), rrr_word(OP_OR, 7, 6, 1), rrr_word(OP_AND, 2, 7, 5),
    rri4_word(OP_SRL, 3, 2, 1), ri8_word(OP_SUBI, 3, 8'h05), rri4_word(OP_SLA, 4, 3, 4),
    rri4_word(OP_STORE, 1, 0, 0), rri4_word(OP_STORE, 2, 0, 1), rri4_word(OP_STORE, 3, 0, 2),
    rri4_word(OP_STORE, 4, 0, 3), rri4_word(OP_STORE, 5, 0, 4), rri4_word(OP_STORE, 6, 0, 5),
    rri4_word(OP_STORE, 7, 0, 6), ri8_word(OP_HALT, 0, 0),
    // Load-use
    rri4_word(OP_LOAD, 1, 0, 2), rrr_word(OP_ADD, 2, 1, 1), rri4_word(OP_STORE, 2, 0, 8),
    rri4_word(OP_LOAD, 3, 0, 5), rri4_word(OP_STORE, 3, 0, 9), rri4_word(OP_LOAD, 4, 0, 7),
    ri8_word(OP_ADDI, 4, 8'h01), rri4_word(OP_LOAD, 5, 0, 3), ri8_word(OP_NOP, 0, 0),
    rrr_word(OP_SUB, 6, 5, 4), rri4_word(OP_STORE, 4, 0, 10), rri4_word(OP_STORE, 6, 0, 11),
    ri8_word(OP_HALT, 0, 0),
    // Branches, jumps and squashed stores
    ri8_word(OP_ADDI, 1, 3), ri8_word(OP_SUBI, 1, 1), rri4_word(OP_STORE, 1, 0, 1),
    ri8_word(OP_BNZ, 0, 1), ri8_word(OP_ADDI, 2, 8'h40), ri8_word(OP_BZ, 0, 9),
    ri8_word(OP_JUMP, 0, 10), rri4_word(OP_STORE, 2, 0, 3), rri4_word(OP_STORE, 2, 0, 4),
    rri4_word(OP_STORE, 2, 0, 5), ri8_word(OP_ADDI, 3, 14), ri8_word(OP_JMPR, 3, 2),
    rri4_word(OP_STORE, 3, 0, 6), rri4_word(OP_STORE, 3, 0, 6), rri4_word(OP_STORE, 3, 0, 6),
    ri8_word(OP_HALT, 0, 0), ri8_word(OP_SUBI, 1, 1), ri8_word(OP_BN, 0, 21),
    rri4_word(OP_STORE, 1, 0, 8), rri4_word(OP_STORE, 1, 0, 8), rri4_word(OP_STORE, 1, 0, 8),
    ri8_word(OP_BNN, 0, 25), rri4_word(OP_STORE, 1, 0, 7), ri8_word(OP_HALT, 0, 0),
    // Carry chain and compares
    ri8_word(OP_LDIH, 1, 8'hff), ri8_word(OP_ADDI, 1, 8'hff), ri8_word(OP_ADDI, 2, 1),
    rrr_word(OP_ADD, 3, 1, 2), rrr_word(OP_ADDC, 4, 2, 2), rri4_word(OP_STORE, 3, 0, 0),
    rri4_word(OP_STORE, 4, 0, 1), rrr_word(OP_CMP, 0, 2, 1), ri8_word(OP_BC, 0, 12),
    rri4_word(OP_STORE, 1, 0, 2), rri4_word(OP_STORE, 1, 0, 2), rri4_word(OP_STORE, 1, 0, 2),
    rrr_word(OP_SUBC, 5, 2, 0), rri4_word(OP_STORE, 5, 0, 3), rrr_word(OP_CMP, 0, 1, 2),
    ri8_word(OP_BNC, 0, 19), rri4_word(OP_STORE, 1, 0, 6), rri4_word(OP_STORE, 1, 0, 6),
    rri4_word(OP_STORE, 1, 0, 6), rrr_word(OP_SUBC, 6, 2, 1), rrr_word(OP_ADDC, 7, 0, 0),
    rri4_word(OP_STORE, 6, 0, 4), rri4_word(OP_STORE, 7, 0, 5), ri8_word(OP_HALT, 0, 0),
    // HALT with stores behind it
    ri8_word(OP_ADDI, 1, 8'h11), ri8_word(OP_ADDI, 2, 8'h22), rrr_word(OP_ADD, 3, 1, 2),
    rri4_word(OP_STORE, 3, 0, 0), rri4_word(OP_SLL, 4, 3, 2), rri4_word(OP_STORE, 4, 0, 1),
    rrr_word(OP_XOR, 5, 4, 1), rri4_word(OP_STORE, 5, 0, 2), ri8_word(OP_HALT, 0, 0),
    ri8_word(OP_NOP, 0, 0), rri4_word(OP_STORE, 5, 0, 3), rri4_word(OP_STORE, 5, 0, 4)
};

// ==== tb/tb_cpu.sv ====
module tb_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    import cpu_pkg::*;

    `include "tb_programs.svh"

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int MODEL_STEPS    = 1000;

    logic   clock;
    logic   reset;
    logic   enable;
    logic   start;
    word_t  i_data;
    word_t  d_data;
    addr_t  i_addr;
    addr_t  d_addr;
    word_t  d_dataout;
    logic   d_we;
    logic   running;

    word_t  imem [256];
    word_t  dmem [256];
    integer seed;

    logic   we_seen;
    addr_t  addr_seen;
    word_t  data_seen;

    addr_t  got_addr [$];
    word_t  got_data [$];
    addr_t  exp_addr [$];
    word_t  exp_data [$];

    cpu_top uut (
        .i_clock(clock), .i_reset(reset), .i_enable(enable), .i_start(start),
        .i_i_data(i_data), .i_d_data(d_data), .o_i_addr(i_addr), .o_d_addr(d_addr),
        .o_d_dataout(d_dataout), .o_d_we(d_we), .o_running(running)
    );

    assign i_data = imem[i_addr];
    assign d_data = dmem[d_addr];

    initial
    begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    //////////////////////////////////////////////////////////////////////
    // Data memory write port

    // Sampled mid-cycle, committed at the next rising edge
    always @(negedge clock)
    begin
        we_seen   = d_we;
        addr_seen = d_addr;
        data_seen = d_dataout;
    end

    always @(posedge clock)
    begin
        if (we_seen === 1'b1)
        begin
            dmem[addr_seen] <= data_seen;
            got_addr.push_back(addr_seen);
            got_data.push_back(data_seen);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers

    task automatic fail_with(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            fail_with($sformatf("Mismatch %s: got %h, expected %h", name, actual, expected));
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #5;
    endtask

    task automatic wait_for_running(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (running !== level)
        begin
            if (cycles == TIMEOUT_CYCLES)
                fail_with({"Timed out waiting for ", what});
            next_cycle();
            cycles++;
        end
    endtask

    task automatic pulse_start();
        enable = 1'b1;
        start  = 1'b1;
        next_cycle();
        start  = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sequential reference interpreter

    task automatic run_model();
        word_t       regs [8];
        word_t       mem [256];
        word_t       ir;
        word_t       imm8;
        logic [16:0] wide;
        logic [2:0]  r1;
        logic [2:0]  r2;
        logic [2:0]  r3;
        addr_t       pc;
        addr_t       ea;
        addr_t       target;
        opcode_t     op;
        logic        z;
        logic        n;
        logic        c;
        logic        arith;
        logic        halted;
        int          steps;
        for (int i = 0; i < 8; i++)
            regs[i] = '0;
        mem = dmem;
        pc = '0;
        z = 1'b0;
        n = 1'b0;
        c = 1'b0;
        halted = 1'b0;
        steps = 0;
        exp_addr.delete();
        exp_data.delete();
        while (!halted)
        begin
            if (steps == MODEL_STEPS)
                fail_with("Reference model never reached HALT");
            steps++;
            ir     = imem[pc];
            op     = opcode_t'(ir[15:11]);
            r1     = ir[10:8];
            r2     = ir[6:4];
            r3     = ir[2:0];
            imm8   = {8'h00, ir[7:0]};
            ea     = addr_t'(regs[r2] + {12'h000, ir[3:0]});
            target = addr_t'(regs[r1] + imm8);
            pc     = pc + 8'd1;
            arith  = 1'b0;
            wide   = '0;
            case (op)
                OP_HALT: halted = 1'b1;
                OP_LOAD: regs[r1] = mem[ea];
                OP_STORE:
                begin
                    mem[ea] = regs[r1];
                    exp_addr.push_back(ea);
                    exp_data.push_back(regs[r1]);
                end
                OP_SLL, OP_SLA: regs[r1] = regs[r2] << ir[3:0];
                OP_SRL: regs[r1] = regs[r2] >> ir[3:0];
                OP_SRA: regs[r1] = word_t'($signed(regs[r2]) >>> ir[3:0]);
                OP_AND: regs[r1] = regs[r2] & regs[r3];
                OP_OR:  regs[r1] = regs[r2] | regs[r3];
                OP_XOR: regs[r1] = regs[r2] ^ regs[r3];
                OP_LDIH:
                begin
                    regs[r1] = regs[r1] + {ir[7:0], 8'h00};
                    z = (regs[r1] == 16'h0000);
                    n = regs[r1][15];
                end
                OP_ADD:  {arith, wide} = {1'b1, {1'b0, regs[r2]} + {1'b0, regs[r3]}};
                OP_ADDI: {arith, wide} = {1'b1, {1'b0, regs[r1]} + {1'b0, imm8}};
                OP_ADDC: {arith, wide} = {1'b1, {1'b0, regs[r2]} + {1'b0, regs[r3]} + 17'(c)};
                OP_SUB, OP_CMP: {arith, wide} = {1'b1, {1'b0, regs[r2]} - {1'b0, regs[r3]}};
                OP_SUBI: {arith, wide} = {1'b1, {1'b0, regs[r1]} - {1'b0, imm8}};
                OP_SUBC: {arith, wide} = {1'b1, {1'b0, regs[r2]} - {1'b0, regs[r3]} - 17'(c)};
                OP_JUMP: pc = ir[7:0];
                OP_JMPR: pc = target;
                OP_BZ:   pc = z ? target : pc;
                OP_BNZ:  pc = !z ? target : pc;
                OP_BN:   pc = n ? target : pc;
                OP_BNN:  pc = !n ? target : pc;
                OP_BC:   pc = c ? target : pc;
                OP_BNC:  pc = !c ? target : pc;
                default: ;
            endcase
            // Bit 16 is carry out, or borrow for subtraction
            if (arith)
            begin
                z = (wide[15:0] == 16'h0000);
                n = wide[15];
                c = wide[16];
                if (op != OP_CMP)
                    regs[r1] = wide[15:0];
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test loop

    initial
    begin
        reset  = 1'b0;
        enable = 1'b0;
        start  = 1'b0;
        seed   = 32'hbb62ced4;
        for (int i = 0; i < 256; i++)
        begin
            imem[i] = '0;
            dmem[i] = '0;
        end

        for (int row = 0; row < NUM_ROWS; row++)
        begin
            reset  = 1'b0;
            enable = 1'b0;
            start  = 1'b0;
            for (int i = 0; i < 256; i++)
            begin
                imem[i] = (i < PROG_LEN[row]) ? PROGRAM_WORDS[PROG_START[row] + i] : '0;
                dmem[i] = word_t'($random(seed));
            end
            got_addr.delete();
            got_data.delete();
            run_model();
            check_value("model store count", 32'(exp_addr.size()), 32'(STORE_COUNT[row]));

            repeat (16) next_cycle();
            reset = 1'b1;
            next_cycle();
            pulse_start();
            wait_for_running(1'b1, "start");
            if (DROP_CYCLE[row] >= 0)
            begin
                repeat (DROP_CYCLE[row]) next_cycle();
                enable = 1'b0;
                wait_for_running(1'b0, "enable drop");
                repeat (3) next_cycle();
                pulse_start();
                wait_for_running(1'b1, "restart");
            end
            wait_for_running(1'b0, "HALT");
            // Late stores would show up here
            repeat (4) next_cycle();

            check_value("store count", 32'(got_addr.size()), 32'(exp_addr.size()));
            foreach (got_addr[i])
            begin
                check_value("o_d_addr", 32'(got_addr[i]), 32'(exp_addr[i]));
                check_value("o_d_dataout", 32'(got_data[i]), 32'(exp_data[i]));
            end
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+tb
hw/cpu_pkg.sv
hw/pipe_if.sv
hw/cpu_control.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/register_file.sv
hw/execute_stage.sv
hw/alu.sv
hw/memory_stage.sv
hw/cpu_top.sv
tb/tb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu
FLAGS     ?= --binary -Wno-fatal
OBJ_DIR   ?= obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f list.f --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f list.f --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
